// File: src/main_bus_consts.svh
/*
 * Main CPU memory map constants: region codes, I/O register offsets
 * and ROM bank bases for the bus glue
 */
`ifndef MAIN_BUS_CONSTS_SVH
`define MAIN_BUS_CONSTS_SVH

// Address bits 15:14
`define MB_LOW_MAP          2'b00
`define MB_BANKED_MAP       2'b01

// Region codes on address bits 13:11 of the low map
`define MB_RAM_REGION0      3'd0
`define MB_RAM_REGION1      3'd1
`define MB_PAL_REGION       3'd2
`define MB_CHAR_REGION      3'd3
`define MB_COM_REGION       3'd4
`define MB_OBJ_REGION       3'd5
`define MB_SCR_REGION       3'd6
`define MB_IO_REGION        3'd7

// I/O register offsets on address bits 2:0
`define MB_IOREG_MISC       3'd0
`define MB_IOREG_HSCR       3'd1
`define MB_IOREG_VSCR       3'd2
`define MB_IOREG_NMICLR     3'd3
`define MB_IOREG_FIRQCLR    3'd4
`define MB_IOREG_IRQCLR     3'd5
`define MB_IOREG_SNDLATCH   3'd6

// Upper ROM address bits for the fixed (non-banked) area
`define MB_FIXED_ROM_BASE   3'b100

`endif

// File: src/main_bus_pkg.sv
/*
 * Shared bus types for the main CPU glue logic
 */
`default_nettype none

package main_bus_pkg;

    // CPU bus as seen by the glue
    typedef struct packed {
        logic [15:0] addr;
        // High on reads
        logic        rnw;
        logic [7:0]  wdata;
        // One clk wide, once per bus cycle
        logic        cen;
    } bus_req_t;

    // Region selects, levels
    typedef struct packed {
        logic ram;
        logic pal;
        logic char;
        logic com;
        logic obj;
        logic scr;
        logic io;
        logic rom;
        // Also sets rom
        logic banked;
    } chip_sel_t;

    // Write strobes and interrupt clears
    typedef struct packed {
        logic misc;
        logic hscroll;
        logic vscroll;
        logic sndlatch;
        logic nmi_clr;
        logic firq_clr;
        logic irq_clr;
    } reg_strobe_t;

    // Register outputs toward the video side
    typedef struct packed {
        logic [8:0] hscroll;
        logic [8:0] vscroll;
        logic       flip;
    } video_ctrl_t;

    // Cabinet switches, active low as wired
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [6:0] joy1;
        logic [6:0] joy2;
        logic       service;
    } cab_in_t;

endpackage

`default_nettype wire

// File: src/addr_decoder.sv
/*
 * Main CPU address decoder: region chip selects, I/O write strobes
 * and registered interrupt clear strobes
 */
`timescale 1ns/10ps
`default_nettype none

`include "main_bus_consts.svh"

module addr_decoder (
    input  wire                       clk,
    input  wire                       rst,
    input  wire main_bus_pkg::bus_req_t bus,
    output main_bus_pkg::chip_sel_t   sel,
    output main_bus_pkg::reg_strobe_t strb
);

    logic       io_area;
    // Clear strobes: nmi, firq, irq
    logic [2:0] clr_q;

    assign io_area = (bus.addr[15:14] == `MB_LOW_MAP) &&
                     (bus.addr[13:11] == `MB_IO_REGION);

    always_comb begin
        sel  = '0;
        strb = '0;
        // Clears come from the flops below
        strb.nmi_clr  = clr_q[2];
        strb.firq_clr = clr_q[1];
        strb.irq_clr  = clr_q[0];
        if (bus.addr[15:14] == `MB_LOW_MAP) begin
            case (bus.addr[13:11])
                `MB_RAM_REGION0, `MB_RAM_REGION1: sel.ram = 1'b1;
                `MB_PAL_REGION:  sel.pal  = 1'b1;
                `MB_CHAR_REGION: sel.char = 1'b1;
                `MB_COM_REGION:  sel.com  = 1'b1;
                `MB_OBJ_REGION:  sel.obj  = 1'b1;
                `MB_SCR_REGION:  sel.scr  = 1'b1;
                `MB_IO_REGION: begin
                    // Input port only answers reads
                    sel.io = bus.rnw;
                    // Write registers sit at offsets with bit 3 set
                    if (!bus.rnw && bus.addr[3]) begin
                        case (bus.addr[2:0])
                            `MB_IOREG_MISC:     strb.misc     = 1'b1;
                            `MB_IOREG_HSCR:     strb.hscroll  = 1'b1;
                            `MB_IOREG_VSCR:     strb.vscroll  = 1'b1;
                            `MB_IOREG_SNDLATCH: strb.sndlatch = 1'b1;
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end else begin
            // Upper 48k is ROM, 4000-7FFF goes through the bank
            sel.rom    = 1'b1;
            sel.banked = (bus.addr[15:14] == `MB_BANKED_MAP);
        end
    end

    // Interrupt acknowledges, reads or writes alike
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_q <= '0;
        end else begin
            clr_q[2] <= io_area && (bus.addr[2:0] == `MB_IOREG_NMICLR);
            clr_q[1] <= io_area && (bus.addr[2:0] == `MB_IOREG_FIRQCLR);
            clr_q[0] <= io_area && (bus.addr[2:0] == `MB_IOREG_IRQCLR);
        end
    end

    // At most one region, banked only inside rom
    sel_onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({sel.ram, sel.pal, sel.char, sel.com, sel.obj, sel.scr, sel.io, sel.rom})
        && (!sel.banked || sel.rom));

endmodule

`default_nettype wire

// File: src/io_regs.sv
/*
 * Write-only hardware registers: scroll, flip, ROM bank,
 * MCU control and the sound latch with its IRQ pulse
 */
`timescale 1ns/10ps
`default_nettype none

module io_regs (
    input  wire                         clk,
    input  wire                         rst,
    input  wire main_bus_pkg::bus_req_t bus,
    input  wire main_bus_pkg::reg_strobe_t strb,
    output main_bus_pkg::video_ctrl_t   video,
    output logic [2:0]                  bank,
    output logic                        mcu_rstb,
    output logic                        mcu_halt,
    output logic [7:0]                  snd_latch,
    output logic                        snd_irq
);

    // Writes land on the bus enable only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            video     <= '0;
            bank      <= 3'd0;
            mcu_rstb  <= 1'b0;
            mcu_halt  <= 1'b0;
            snd_latch <= 8'd0;
            snd_irq   <= 1'b0;
        end else if (bus.cen) begin
            // IRQ to the sound CPU lasts one bus cycle
            snd_irq <= 1'b0;
            if (strb.sndlatch) begin
                snd_latch <= bus.wdata;
                snd_irq   <= 1'b1;
            end

            // Scroll low bytes
            if (strb.hscroll) begin
                video.hscroll[7:0] <= bus.wdata;
            end
            if (strb.vscroll) begin
                video.vscroll[7:0] <= bus.wdata;
            end

            // Misc latch
            if (strb.misc) begin
                // Scroll ninth bits
                video.hscroll[8] <= bus.wdata[0];
                video.vscroll[8] <= bus.wdata[1];
                video.flip       <= bus.wdata[2];
                // MCU reset and halt lines
                mcu_rstb         <= bus.wdata[3];
                mcu_halt         <= bus.wdata[4];
                // ROM bank for 4000-7FFF
                bank             <= bus.wdata[7:5];
            end
        end
    end

    // Sound CPU never sees two latch writes back to back
    snd_irq_single_a: assert property (@(posedge clk) disable iff (rst)
        (bus.cen && snd_irq) |=> !snd_irq);

endmodule

`default_nettype wire

// File: src/cabinet_port.sv
/*
 * Cabinet input port: registered byte picked by the I/O offset
 */
`timescale 1ns/10ps
`default_nettype none

module cabinet_port (
    input  wire                         clk,
    input  wire main_bus_pkg::bus_req_t bus,
    input  wire main_bus_pkg::cab_in_t  cab,
    input  wire [7:0]                   dipsw_a,
    input  wire [7:0]                   dipsw_b,
    input  wire                         mcu_ban,
    input  wire                         vbl,
    output logic [7:0]                  io_data
);

    // Board wiring has joystick bits 2 and 3 crossed
    function automatic logic [5:0] swap_joy(input logic [5:0] joy);
        return {joy[5:4], joy[2], joy[3], joy[1:0]};
    endfunction

    // Sampled every clk, read one clk after the address settles
    always_ff @(posedge clk) begin
        case (bus.addr[3:0])
            // Start buttons, player 1
            4'd0: io_data <= {cab.start, swap_joy(cab.joy1[5:0])};
            // Coins, player 2
            4'd1: io_data <= {cab.coin, swap_joy(cab.joy2[5:0])};
            // Status byte
            4'd2: io_data <= {3'b111, mcu_ban, vbl,
                              cab.joy2[6], cab.joy1[6], cab.service};
            4'd3: io_data <= dipsw_a;
            4'd4: io_data <= dipsw_b;
            // Open bus reads high
            default: io_data <= 8'hff;
        endcase
    end

endmodule

`default_nettype wire

// File: src/irq_latch.sv
/*
 * NMI, FIRQ and IRQ request latches: set on rising input edges,
 * cleared by the acknowledge strobes
 */
`timescale 1ns/10ps
`default_nettype none

module irq_latch (
    input  wire                         clk,
    input  wire                         rst,
    input  wire main_bus_pkg::bus_req_t bus,
    input  wire                         vbl,
    input  wire                         dip_pause,
    input  wire                         ims,
    input  wire                         mcu_irqmain,
    input  wire main_bus_pkg::reg_strobe_t strb,
    output logic                        nmi_n,
    output logic                        firq_n,
    output logic                        irq_n
);

    logic       vbl_pause;
    logic       ims_s;
    // Channels: nmi, firq, irq
    logic [2:0] src;
    logic [2:0] src_d1;
    logic [2:0] src_d2;
    logic [2:0] rise;
    logic [2:0] clr;
    logic [2:0] req;

    // VBL and IMS move at the CPU bus rate
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vbl_pause <= 1'b0;
            ims_s     <= 1'b0;
        end else if (bus.cen) begin
            vbl_pause <= vbl & dip_pause;
            ims_s     <= ims;
        end
    end

    assign src  = {vbl_pause, ims_s, mcu_irqmain};
    assign clr  = {strb.nmi_clr, strb.firq_clr, strb.irq_clr};
    assign rise = src_d1 & ~src_d2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_d1 <= '0;
            src_d2 <= '0;
            req    <= '0;
        end else begin
            src_d1 <= src;
            src_d2 <= src_d1;
            // Acknowledge beats a new edge
            req    <= (req | rise) & ~clr;
        end
    end

    // Request lines are active low
    assign nmi_n  = ~req[2];
    assign firq_n = ~req[1];
    assign irq_n  = ~req[0];

    // Each request follows a 0->1 step of its source two clks before
    for (genvar i = 0; i < 3; i++) begin : g_req_chk
        req_after_edge_a: assert property (@(posedge clk) disable iff (rst)
            $rose(req[i]) |-> ($past(src[i], 2) && !$past(src[i], 3)));
    end

endmodule

`default_nettype wire

// File: src/read_mux.sv
/*
 * CPU read data multiplexer and banked ROM address former
 */
`timescale 1ns/10ps
`default_nettype none

`include "main_bus_consts.svh"

module read_mux (
    input  wire main_bus_pkg::bus_req_t  bus,
    input  wire main_bus_pkg::chip_sel_t sel,
    input  wire [2:0]                    bank,
    input  wire [7:0]                    ram_dout,
    input  wire [7:0]                    pal_dout,
    input  wire [7:0]                    char_dout,
    input  wire [7:0]                    obj_dout,
    input  wire [7:0]                    scr_dout,
    input  wire [7:0]                    mcu_ram,
    input  wire [7:0]                    rom_data,
    input  wire [7:0]                    io_data,
    output logic [7:0]                   cpu_din,
    output logic [17:0]                  rom_addr
);

    // First active select wins
    always_comb begin
        case (1'b1)
            sel.ram:    cpu_din = ram_dout;
            sel.char:   cpu_din = char_dout;
            sel.scr:    cpu_din = scr_dout;
            // Banked window also raises rom
            sel.rom:    cpu_din = rom_data;
            // Registered cabinet byte
            sel.io:     cpu_din = io_data;
            sel.pal:    cpu_din = pal_dout;
            sel.obj:    cpu_din = obj_dout;
            // Shared RAM with the MCU
            sel.com:    cpu_din = mcu_ram;
            default:    cpu_din = 8'hff;
        endcase
    end

    // 16k pages, banked window or fixed top of ROM
    always_comb begin
        rom_addr[13:0] = bus.addr[13:0];
        if (sel.banked) begin
            rom_addr[17:14] = {1'b0, bank};
        end else begin
            rom_addr[17:14] = {`MB_FIXED_ROM_BASE, bus.addr[14]};
        end
    end

endmodule

`default_nettype wire

// File: src/main_bus.sv
/*
 * Main CPU bus glue top: decoder, registers, cabinet port,
 * interrupt latches and read multiplexer
 */
`timescale 1ns/10ps
`default_nettype none

module main_bus (
    input  wire                          clk,
    input  wire                          rst,
    // CPU side
    input  wire main_bus_pkg::bus_req_t  bus,
    output wire [7:0]                    cpu_din,
    // Memory read data
    input  wire [7:0]                    ram_dout,
    input  wire [7:0]                    pal_dout,
    input  wire [7:0]                    char_dout,
    input  wire [7:0]                    obj_dout,
    input  wire [7:0]                    scr_dout,
    input  wire [7:0]                    mcu_ram,
    input  wire [7:0]                    rom_data,
    output main_bus_pkg::chip_sel_t      sel,
    output wire [17:0]                   rom_addr,
    // Cabinet and DIP switches
    input  wire main_bus_pkg::cab_in_t   cab,
    input  wire [7:0]                    dipsw_a,
    input  wire [7:0]                    dipsw_b,
    input  wire                          dip_pause,
    // Video timing and MCU status
    input  wire                          vbl,
    input  wire                          ims,
    input  wire                          mcu_irqmain,
    input  wire                          mcu_ban,
    // Register outputs
    output main_bus_pkg::video_ctrl_t    video,
    output wire [2:0]                    bank,
    output wire                          mcu_rstb,
    output wire                          mcu_halt,
    output wire [7:0]                    snd_latch,
    output wire                          snd_irq,
    // CPU interrupt requests
    output wire                          nmi_n,
    output wire                          firq_n,
    output wire                          irq_n
);

    main_bus_pkg::reg_strobe_t strb;
    wire [7:0]                 io_data;

    addr_decoder u_decoder (
        .clk  (clk),
        .rst  (rst),
        .bus  (bus),
        .sel  (sel),
        .strb (strb)
    );

    io_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .strb      (strb),
        .video     (video),
        .bank      (bank),
        .mcu_rstb  (mcu_rstb),
        .mcu_halt  (mcu_halt),
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq)
    );

    cabinet_port u_cabinet (
        .clk     (clk),
        .bus     (bus),
        .cab     (cab),
        .dipsw_a (dipsw_a),
        .dipsw_b (dipsw_b),
        .mcu_ban (mcu_ban),
        .vbl     (vbl),
        .io_data (io_data)
    );

    irq_latch u_irq (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .vbl         (vbl),
        .dip_pause   (dip_pause),
        .ims         (ims),
        .mcu_irqmain (mcu_irqmain),
        .strb        (strb),
        .nmi_n       (nmi_n),
        .firq_n      (firq_n),
        .irq_n       (irq_n)
    );

    read_mux u_mux (
        .bus       (bus),
        .sel       (sel),
        .bank      (bank),
        .ram_dout  (ram_dout),
        .pal_dout  (pal_dout),
        .char_dout (char_dout),
        .obj_dout  (obj_dout),
        .scr_dout  (scr_dout),
        .mcu_ram   (mcu_ram),
        .rom_data  (rom_data),
        .io_data   (io_data),
        .cpu_din   (cpu_din),
        .rom_addr  (rom_addr)
    );

endmodule

`default_nettype wire

// File: testbench/tb_main_bus.sv
/*
 * Main CPU bus glue testbench: plays the CPU from the cases file
 * and checks read data, register outputs and interrupt lines
 */
`timescale 1ns/10ps
`default_nettype none

module tb_main_bus;

    // Bus parked on a harmless RAM read between operations
    localparam logic [15:0] park_addr = 16'h0000;

    logic                      clk;
    logic                      rst;
    logic [15:0]               bus_addr;
    logic                      bus_rnw;
    logic [7:0]                bus_wdata;
    logic                      bus_cen;
    main_bus_pkg::bus_req_t    bus;
    logic [7:0]                ram_dout;
    logic [7:0]                pal_dout;
    logic [7:0]                char_dout;
    logic [7:0]                obj_dout;
    logic [7:0]                scr_dout;
    logic [7:0]                mcu_ram;
    logic [7:0]                rom_data;
    main_bus_pkg::cab_in_t     cab;
    logic [7:0]                dipsw_a;
    logic [7:0]                dipsw_b;
    logic                      dip_pause;
    logic                      vbl;
    logic                      ims;
    logic                      mcu_irqmain;
    logic                      mcu_ban;
    logic [7:0]                cpu_din;
    main_bus_pkg::chip_sel_t   sel;
    logic [17:0]               rom_addr;
    main_bus_pkg::video_ctrl_t video;
    logic [2:0]                bank;
    logic                      mcu_rstb;
    logic                      mcu_halt;
    logic [7:0]                snd_latch;
    logic                      snd_irq;
    logic                      nmi_n;
    logic                      firq_n;
    logic                      irq_n;

    // Case lines as read from the file
    logic [7:0]                op_q[$];
    logic [31:0]               arg_q[$];
    logic [31:0]               data_q[$];
    logic [31:0]               exp_q[$];

    int                        errors = 0;
    int                        cycles = 0;
    int                        cycle_limit = 200;
    int                        snd_pulses = 0;
    int                        pulses_seen = 0;
    int                        snd_width = 0;
    logic                      snd_irq_q = 1'b0;

    // Field order matches bus_req_t
    assign bus = {bus_addr, bus_rnw, bus_wdata, bus_cen};

    main_bus i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no end of test after %0d clock cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // Sound IRQ rising edges and pulse width in clks
    always @(negedge clk) begin
        snd_irq_q <= snd_irq;
        if (snd_irq && !snd_irq_q) begin
            snd_pulses <= snd_pulses + 1;
            snd_width  <= 1;
        end else if (snd_irq) begin
            snd_width <= snd_width + 1;
            // One bus period is four clks
            if (snd_width == 4) begin
                $display("snd_irq still high after one bus period at %0t", $time);
                errors++;
            end
        end else if (snd_irq_q && snd_width != 4) begin
            $display("Mismatch at %0t: snd_irq width expected 4 clks, got %0d",
                     $time, snd_width);
            errors++;
        end
    end

    task automatic load_cases;
        int                 fd;
        int                 n;
        logic [8*8-1:0]     tok;
        logic [8*128-1:0]   skip;
        logic [31:0]        a;
        logic [31:0]        d;
        logic [31:0]        e;
        fd = $fopen("testbench/main_bus_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                break;
            end
            // Rest of a comment line is dropped
            if (tok[7:0] == "#") begin
                n = $fgets(skip, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3) begin
                    $display("Cases file line after opcode %s is incomplete", tok);
                    errors++;
                    break;
                end
                op_q.push_back(tok[7:0]);
                arg_q.push_back(a);
                data_q.push_back(d);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // One bus period, cen on its last clk
    task automatic bus_period(input logic [15:0] a, input logic rnw, input logic [7:0] d);
        @(negedge clk);
        bus_addr  = a;
        bus_rnw   = rnw;
        bus_wdata = d;
        bus_cen   = 1'b0;
        repeat (2) @(negedge clk);
        @(negedge clk);
        bus_cen = 1'b1;
    endtask

    task automatic set_input(input logic [7:0] which, input logic [31:0] value);
        case (which)
            8'h0: ram_dout    = value[7:0];
            8'h1: pal_dout    = value[7:0];
            8'h2: char_dout   = value[7:0];
            8'h3: obj_dout    = value[7:0];
            8'h4: scr_dout    = value[7:0];
            8'h5: mcu_ram     = value[7:0];
            8'h6: rom_data    = value[7:0];
            8'h7: dipsw_a     = value[7:0];
            8'h8: dipsw_b     = value[7:0];
            8'h9: cab         = value[18:0];
            8'ha: vbl         = value[0];
            8'hb: ims         = value[0];
            8'hc: mcu_irqmain = value[0];
            8'hd: mcu_ban     = value[0];
            8'he: dip_pause   = value[0];
            default: begin
                $display("Unknown input selector %h in cases file", which);
                errors++;
            end
        endcase
    endtask

    // Region selects as the memory map defines them
    function automatic main_bus_pkg::chip_sel_t expected_sel(input logic [15:0] a,
                                                             input logic rnw);
        main_bus_pkg::chip_sel_t s;
        s = '0;
        if (a[15:14] != 2'b00) begin
            s.rom    = 1'b1;
            s.banked = (a[15:14] == 2'b01);
        end else begin
            case (a[13:11])
                3'd0, 3'd1: s.ram  = 1'b1;
                3'd2:       s.pal  = 1'b1;
                3'd3:       s.char = 1'b1;
                3'd4:       s.com  = 1'b1;
                3'd5:       s.obj  = 1'b1;
                3'd6:       s.scr  = 1'b1;
                // Cabinet port answers reads only
                default:    s.io   = rnw;
            endcase
        end
        return s;
    endfunction

    function automatic string output_name(input logic [7:0] which);
        case (which)
            8'h0: return "video.hscroll";
            8'h1: return "video.vscroll";
            8'h2: return "video.flip";
            8'h3: return "bank";
            8'h4: return "mcu_rstb";
            8'h5: return "mcu_halt";
            8'h6: return "snd_latch";
            8'h7: return "snd_irq pulses";
            8'h8: return "nmi_n";
            8'h9: return "firq_n";
            default: return "irq_n";
        endcase
    endfunction

    function automatic logic [31:0] output_value(input logic [7:0] which);
        case (which)
            8'h0: return {23'd0, video.hscroll};
            8'h1: return {23'd0, video.vscroll};
            8'h2: return {31'd0, video.flip};
            8'h3: return {29'd0, bank};
            8'h4: return {31'd0, mcu_rstb};
            8'h5: return {31'd0, mcu_halt};
            8'h6: return {24'd0, snd_latch};
            // Pulses since the previous pulse check
            8'h7: return snd_pulses - pulses_seen;
            8'h8: return {31'd0, nmi_n};
            8'h9: return {31'd0, firq_n};
            default: return {31'd0, irq_n};
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        bus_addr    = park_addr;
        bus_rnw     = 1'b1;
        bus_wdata   = 8'h00;
        bus_cen     = 1'b0;
        ram_dout    = 8'h00;
        pal_dout    = 8'h00;
        char_dout   = 8'h00;
        obj_dout    = 8'h00;
        scr_dout    = 8'h00;
        mcu_ram     = 8'h00;
        rom_data    = 8'h00;
        cab         = '0;
        dipsw_a     = 8'h00;
        dipsw_b     = 8'h00;
        dip_pause   = 1'b0;
        vbl         = 1'b0;
        ims         = 1'b0;
        mcu_irqmain = 1'b0;
        mcu_ban     = 1'b0;
        load_cases();
        cycle_limit = 64 * op_q.size() + 200;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": begin
                    bus_period(arg_q[i][15:0], 1'b0, data_q[i][7:0]);
                    compare_value("sel", {23'd0, expected_sel(arg_q[i][15:0], 1'b0)},
                                  {23'd0, sel});
                end
                "R": begin
                    bus_period(arg_q[i][15:0], 1'b1, 8'h00);
                    compare_value("cpu_din", exp_q[i], {24'd0, cpu_din});
                    compare_value("sel", {23'd0, expected_sel(arg_q[i][15:0], 1'b1)},
                                  {23'd0, sel});
                    // ROM space also checks the formed address
                    if (arg_q[i][15:14] != 2'b00) begin
                        compare_value("rom_addr", data_q[i], {14'd0, rom_addr});
                    end
                end
                "S": begin
                    set_input(arg_q[i][7:0], data_q[i]);
                    bus_period(park_addr, 1'b1, 8'h00);
                end
                "P": begin
                    // High for one bus period, then low for one
                    set_input(arg_q[i][7:0], 32'd1);
                    bus_period(park_addr, 1'b1, 8'h00);
                    set_input(arg_q[i][7:0], 32'd0);
                    bus_period(park_addr, 1'b1, 8'h00);
                end
                "C": begin
                    bus_period(park_addr, 1'b1, 8'h00);
                    if (arg_q[i][7:0] > 8'ha) begin
                        $display("Unknown output selector %h in cases file", arg_q[i][7:0]);
                        errors++;
                    end else begin
                        compare_value(output_name(arg_q[i][7:0]), exp_q[i],
                                      output_value(arg_q[i][7:0]));
                    end
                    if (arg_q[i][7:0] == 8'h7) begin
                        pulses_seen = snd_pulses;
                    end
                end
                default: begin
                    $display("Unknown opcode %s in cases file", op_q[i]);
                    errors++;
                end
            endcase
        end

        @(negedge clk);
        bus_cen = 1'b0;
        $display("Case lines run: %0d, errors: %0d", op_q.size(), errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/main_bus_cases.txt
# op addr_or_selector data expected, hex; W write, R read (data = rom_addr in ROM), C check
# S set input (data = value), P pulse input high then low; selectors are listed in tb_main_bus
C 0 0 0
C 3 0 0
C 7 0 0
C 8 0 1
C 9 0 1
C a 0 1
S 0 11 0
S 1 22 0
S 2 33 0
S 3 44 0
S 4 55 0
S 5 66 0
S 6 77 0
R 0000 0 11
R 0800 0 11
R 1000 0 22
R 1800 0 33
R 2000 0 66
R 2800 0 44
R 3000 0 55
R 380f 0 ff
R 4000 0 77
R 8000 20000 77
W 3809 5a 0
W 380a c3 0
W 3808 6d 0
C 0 0 15a
C 1 0 c3
C 2 0 1
C 3 0 3
C 4 0 1
C 5 0 0
R 4abc cabc 77
W 3800 ff 0
W 3801 00 0
W 3802 00 0
W 3806 00 0
C 0 0 15a
C 1 0 c3
C 3 0 3
W 3808 92 0
C 0 0 5a
C 1 0 1c3
C 2 0 0
C 3 0 4
C 4 0 0
C 5 0 1
R 5234 11234 77
R 7fff 13fff 77
R c123 24123 77
W 380e 3c 0
C 6 0 3c
C 7 0 1
S 7 a5 0
S 8 3c 0
S 9 4c413 0
S d 1 0
R 3800 0 88
R 3801 0 45
R 3802 0 f3
R 3803 0 a5
R 3804 0 3c
R 3807 0 ff
S c 1 0
C a 0 0
S c 0 0
R 380d 0 ff
C a 0 1
P b 0 0
C 9 0 0
W 3804 00 0
C 9 0 1
P a 0 0
C 8 0 1
S e 1 0
P a 0 0
C 8 0 0
W 380b 00 0
C 8 0 1

// File: files.f
+incdir+src
src/main_bus_pkg.sv
src/addr_decoder.sv
src/io_regs.sv
src/cabinet_port.sv
src/irq_latch.sv
src/read_mux.sv
src/main_bus.sv
testbench/tb_main_bus.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_main_bus
FILELIST = files.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
